// ==== hdl/idw_pkg.sv ====
// Widths, sizes, payload types and the shared-bus ID union of the AXI ID slice
package idw_pkg;

  localparam int unsigned NumReq         = 2;
  localparam int unsigned IdWidthReq     = 2;
  localparam int unsigned IdWidthBus     = 3;
  localparam int unsigned IdWidthMem     = 1;
  localparam int unsigned RemapTableSize = 2;
  localparam int unsigned AddrWidth      = 6;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned MemWords       = 64;
  localparam int unsigned MaxPending     = 7;
  // Counter wide enough to hold MaxPending
  localparam int unsigned CntWidth       = $clog2(MaxPending + 1);

  typedef logic [IdWidthReq-1:0] req_id_t;
  typedef logic [IdWidthMem-1:0] mem_id_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [StrbWidth-1:0]  strb_t;
  typedef logic [1:0]            resp_t;
  typedef logic [CntWidth-1:0]   cnt_t;

  localparam resp_t RespOkay = 2'b00;

  // Requester index on top, requester's own ID below
  typedef struct packed {
    logic    src;
    req_id_t id;
  } bus_id_fields_t;

  // Decoded by the mux as fields, by the converter as one opaque word
  typedef union packed {
    bus_id_fields_t        f;
    logic [IdWidthBus-1:0] raw;
  } bus_id_u;

endpackage

// ==== hdl/axi_rr_id_mux.sv ====
// Round-robin AXI arbiter of two requesters with ID prefixing and response routing
module axi_rr_id_mux (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Requester 0
  input  logic             req0_aw_valid_i, req0_w_valid_i, req0_ar_valid_i,
  input  logic             req0_b_ready_i, req0_r_ready_i,
  output logic             req0_aw_ready_o, req0_w_ready_o, req0_ar_ready_o,
  output logic             req0_b_valid_o, req0_r_valid_o,
  input  idw_pkg::req_id_t req0_aw_id_i, req0_ar_id_i,
  input  idw_pkg::addr_t   req0_aw_addr_i, req0_ar_addr_i,
  input  idw_pkg::data_t   req0_w_data_i,
  input  idw_pkg::strb_t   req0_w_strb_i,
  output idw_pkg::req_id_t req0_b_id_o, req0_r_id_o,
  output idw_pkg::resp_t   req0_b_resp_o, req0_r_resp_o,
  output idw_pkg::data_t   req0_r_data_o,
  // Requester 1
  input  logic             req1_aw_valid_i, req1_w_valid_i, req1_ar_valid_i,
  input  logic             req1_b_ready_i, req1_r_ready_i,
  output logic             req1_aw_ready_o, req1_w_ready_o, req1_ar_ready_o,
  output logic             req1_b_valid_o, req1_r_valid_o,
  input  idw_pkg::req_id_t req1_aw_id_i, req1_ar_id_i,
  input  idw_pkg::addr_t   req1_aw_addr_i, req1_ar_addr_i,
  input  idw_pkg::data_t   req1_w_data_i,
  input  idw_pkg::strb_t   req1_w_strb_i,
  output idw_pkg::req_id_t req1_b_id_o, req1_r_id_o,
  output idw_pkg::resp_t   req1_b_resp_o, req1_r_resp_o,
  output idw_pkg::data_t   req1_r_data_o,
  // Shared bus
  output logic             bus_aw_valid_o, bus_w_valid_o, bus_ar_valid_o,
  output logic             bus_b_ready_o, bus_r_ready_o,
  input  logic             bus_aw_ready_i, bus_w_ready_i, bus_ar_ready_i,
  input  logic             bus_b_valid_i, bus_r_valid_i,
  output idw_pkg::bus_id_u bus_aw_id_o, bus_ar_id_o,
  output idw_pkg::addr_t   bus_aw_addr_o, bus_ar_addr_o,
  output idw_pkg::data_t   bus_w_data_o,
  output idw_pkg::strb_t   bus_w_strb_o,
  input  idw_pkg::bus_id_u bus_b_id_i, bus_r_id_i,
  input  idw_pkg::resp_t   bus_b_resp_i, bus_r_resp_i,
  input  idw_pkg::data_t   bus_r_data_i
);

  logic [idw_pkg::NumReq-1:0] wr_req;
  logic [idw_pkg::NumReq-1:0] rd_req;
  logic                       wr_sel;
  logic                       rd_sel;
  logic                       wr_fire;
  logic                       rd_fire;
  logic                       wr_prio_q;
  logic                       rd_prio_q;
  logic                       wr_lock_q;
  logic                       rd_lock_q;
  logic                       wr_lock_sel_q;
  logic                       rd_lock_sel_q;

  // Priority requester first, the other one when it is idle
  function automatic logic rr_pick(logic prio, logic [idw_pkg::NumReq-1:0] req);
    return req[prio] ? prio : !prio;
  endfunction

  assign wr_req = {req1_aw_valid_i & req1_w_valid_i, req0_aw_valid_i & req0_w_valid_i};
  assign rd_req = {req1_ar_valid_i, req0_ar_valid_i};

  // A request already shown on the bus keeps its grant until it transfers
  assign wr_sel = wr_lock_q ? wr_lock_sel_q : rr_pick(wr_prio_q, wr_req);
  assign rd_sel = rd_lock_q ? rd_lock_sel_q : rr_pick(rd_prio_q, rd_req);

  assign wr_fire = bus_aw_valid_o & bus_aw_ready_i & bus_w_ready_i;
  assign rd_fire = bus_ar_valid_o & bus_ar_ready_i;

  assign bus_aw_valid_o = wr_req[wr_sel];
  assign bus_w_valid_o  = wr_req[wr_sel];
  assign bus_aw_id_o.f  = '{src: wr_sel, id: (wr_sel ? req1_aw_id_i : req0_aw_id_i)};
  assign bus_aw_addr_o  = wr_sel ? req1_aw_addr_i : req0_aw_addr_i;
  assign bus_w_data_o   = wr_sel ? req1_w_data_i : req0_w_data_i;
  assign bus_w_strb_o   = wr_sel ? req1_w_strb_i : req0_w_strb_i;
  assign bus_ar_valid_o = rd_req[rd_sel];
  assign bus_ar_id_o.f  = '{src: rd_sel, id: (rd_sel ? req1_ar_id_i : req0_ar_id_i)};
  assign bus_ar_addr_o  = rd_sel ? req1_ar_addr_i : req0_ar_addr_i;

  assign req0_aw_ready_o = wr_fire & !wr_sel;
  assign req0_w_ready_o  = wr_fire & !wr_sel;
  assign req1_aw_ready_o = wr_fire & wr_sel;
  assign req1_w_ready_o  = wr_fire & wr_sel;
  assign req0_ar_ready_o = rd_fire & !rd_sel;
  assign req1_ar_ready_o = rd_fire & rd_sel;

  // Responses go back to the requester named in the ID prefix
  assign req0_b_valid_o = bus_b_valid_i & !bus_b_id_i.f.src;
  assign req1_b_valid_o = bus_b_valid_i & bus_b_id_i.f.src;
  assign req0_b_id_o    = bus_b_id_i.f.id;
  assign req1_b_id_o    = bus_b_id_i.f.id;
  assign req0_b_resp_o  = bus_b_resp_i;
  assign req1_b_resp_o  = bus_b_resp_i;
  assign bus_b_ready_o  = bus_b_id_i.f.src ? req1_b_ready_i : req0_b_ready_i;

  assign req0_r_valid_o = bus_r_valid_i & !bus_r_id_i.f.src;
  assign req1_r_valid_o = bus_r_valid_i & bus_r_id_i.f.src;
  assign req0_r_id_o    = bus_r_id_i.f.id;
  assign req1_r_id_o    = bus_r_id_i.f.id;
  assign req0_r_resp_o  = bus_r_resp_i;
  assign req1_r_resp_o  = bus_r_resp_i;
  assign req0_r_data_o  = bus_r_data_i;
  assign req1_r_data_o  = bus_r_data_i;
  assign bus_r_ready_o  = bus_r_id_i.f.src ? req1_r_ready_i : req0_r_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_prio_q     <= 1'b0;
      rd_prio_q     <= 1'b0;
      wr_lock_q     <= 1'b0;
      rd_lock_q     <= 1'b0;
      wr_lock_sel_q <= 1'b0;
      rd_lock_sel_q <= 1'b0;
    end else begin
      wr_lock_q     <= bus_aw_valid_o & !wr_fire;
      rd_lock_q     <= bus_ar_valid_o & !rd_fire;
      wr_lock_sel_q <= wr_sel;
      rd_lock_sel_q <= rd_sel;
      // The other requester gets priority after a transfer
      if (wr_fire) wr_prio_q <= !wr_sel;
      if (rd_fire) rd_prio_q <= !rd_sel;
    end
  end

endmodule

// ==== hdl/axi_id_remap_table.sv ====
// Remap table from wide bus IDs to narrow slot IDs with outstanding counters per slot
module axi_id_remap_table (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  idw_pkg::bus_id_u push_id_i,
  output logic             full_o,
  output idw_pkg::mem_id_t push_slot_o,
  input  logic             pop_i,
  input  idw_pkg::mem_id_t pop_slot_i,
  output idw_pkg::bus_id_u pop_id_o
);

  idw_pkg::bus_id_u id_q  [idw_pkg::RemapTableSize];
  idw_pkg::cnt_t    cnt_q [idw_pkg::RemapTableSize];
  logic             hit;
  logic             free_any;
  idw_pkg::mem_id_t hit_slot;
  idw_pkg::mem_id_t free_slot;

  // Downward scan so the lowest free slot wins
  always_comb begin
    hit       = 1'b0;
    hit_slot  = '0;
    free_any  = 1'b0;
    free_slot = '0;
    for (int i = idw_pkg::RemapTableSize - 1; i >= 0; i--) begin
      if (cnt_q[i] != '0 && id_q[i].raw == push_id_i.raw) begin
        hit      = 1'b1;
        hit_slot = idw_pkg::mem_id_t'(i);
      end
      if (cnt_q[i] == '0) begin
        free_any  = 1'b1;
        free_slot = idw_pkg::mem_id_t'(i);
      end
    end
  end

  // An active ID keeps its slot so its order toward the memory is kept
  assign push_slot_o = hit ? hit_slot : free_slot;
  assign full_o      = hit ? (cnt_q[hit_slot] == idw_pkg::cnt_t'(idw_pkg::MaxPending))
                           : !free_any;
  assign pop_id_o    = id_q[pop_slot_i];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < idw_pkg::RemapTableSize; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < idw_pkg::RemapTableSize; i++) begin
        cnt_q[i] <= cnt_q[i]
                  + idw_pkg::cnt_t'(push_i && (push_slot_o == idw_pkg::mem_id_t'(i)))
                  - idw_pkg::cnt_t'(pop_i && (pop_slot_i == idw_pkg::mem_id_t'(i)));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) id_q[push_slot_o] <= push_id_i;
  end

  // Memory responses only come back on slots the converter handed out
  a_pop_active: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> cnt_q[pop_slot_i] != '0);

  // The converter blocks the handshake while the table is full
  a_push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

endmodule

// ==== hdl/axi_iw_converter.sv ====
// AXI ID width converter with write and read remap tables, or a passthrough
module axi_iw_converter #(
  parameter int unsigned IdWidthSlv = idw_pkg::IdWidthBus,
  parameter int unsigned IdWidthMst = idw_pkg::IdWidthMem
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Wide side
  input  logic             slv_aw_valid_i, slv_w_valid_i, slv_ar_valid_i,
  input  logic             slv_b_ready_i, slv_r_ready_i,
  output logic             slv_aw_ready_o, slv_w_ready_o, slv_ar_ready_o,
  output logic             slv_b_valid_o, slv_r_valid_o,
  input  idw_pkg::bus_id_u slv_aw_id_i, slv_ar_id_i,
  input  idw_pkg::addr_t   slv_aw_addr_i, slv_ar_addr_i,
  input  idw_pkg::data_t   slv_w_data_i,
  input  idw_pkg::strb_t   slv_w_strb_i,
  output idw_pkg::bus_id_u slv_b_id_o, slv_r_id_o,
  output idw_pkg::resp_t   slv_b_resp_o, slv_r_resp_o,
  output idw_pkg::data_t   slv_r_data_o,
  // Narrow side
  output logic             mst_aw_valid_o, mst_w_valid_o, mst_ar_valid_o,
  output logic             mst_b_ready_o, mst_r_ready_o,
  input  logic             mst_aw_ready_i, mst_w_ready_i, mst_ar_ready_i,
  input  logic             mst_b_valid_i, mst_r_valid_i,
  output idw_pkg::mem_id_t mst_aw_id_o, mst_ar_id_o,
  output idw_pkg::addr_t   mst_aw_addr_o, mst_ar_addr_o,
  output idw_pkg::data_t   mst_w_data_o,
  output idw_pkg::strb_t   mst_w_strb_o,
  input  idw_pkg::mem_id_t mst_b_id_i, mst_r_id_i,
  input  idw_pkg::resp_t   mst_b_resp_i, mst_r_resp_i,
  input  idw_pkg::data_t   mst_r_data_i
);

  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_w_data_o  = slv_w_data_i;
  assign mst_w_strb_o  = slv_w_strb_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign mst_b_ready_o = slv_b_ready_i;
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign mst_r_ready_o = slv_r_ready_i;

  if (IdWidthSlv > IdWidthMst) begin : gen_remap
    logic wr_full;
    logic rd_full;

    axi_id_remap_table i_wr_table (
      .clk_i,
      .rst_n_i,
      .push_i      (slv_aw_valid_i & slv_aw_ready_o),
      .push_id_i   (slv_aw_id_i),
      .full_o      (wr_full),
      .push_slot_o (mst_aw_id_o),
      .pop_i       (mst_b_valid_i & slv_b_ready_i),
      .pop_slot_i  (mst_b_id_i),
      .pop_id_o    (slv_b_id_o)
    );

    axi_id_remap_table i_rd_table (
      .clk_i,
      .rst_n_i,
      .push_i      (slv_ar_valid_i & slv_ar_ready_o),
      .push_id_i   (slv_ar_id_i),
      .full_o      (rd_full),
      .push_slot_o (mst_ar_id_o),
      .pop_i       (mst_r_valid_i & slv_r_ready_i),
      .pop_slot_i  (mst_r_id_i),
      .pop_id_o    (slv_r_id_o)
    );

    // A full table hides the request from the memory and stalls the requester
    assign mst_aw_valid_o = slv_aw_valid_i & !wr_full;
    assign mst_w_valid_o  = slv_w_valid_i & !wr_full;
    assign slv_aw_ready_o = mst_aw_ready_i & !wr_full;
    assign slv_w_ready_o  = mst_w_ready_i & !wr_full;
    assign mst_ar_valid_o = slv_ar_valid_i & !rd_full;
    assign slv_ar_ready_o = mst_ar_ready_i & !rd_full;
  end else begin : gen_passthrough
    assign mst_aw_valid_o = slv_aw_valid_i;
    assign mst_w_valid_o  = slv_w_valid_i;
    assign slv_aw_ready_o = mst_aw_ready_i;
    assign slv_w_ready_o  = mst_w_ready_i;
    assign mst_ar_valid_o = slv_ar_valid_i;
    assign slv_ar_ready_o = mst_ar_ready_i;
    assign mst_aw_id_o    = idw_pkg::mem_id_t'(slv_aw_id_i.raw);
    assign mst_ar_id_o    = idw_pkg::mem_id_t'(slv_ar_id_i.raw);
    assign slv_b_id_o     = idw_pkg::bus_id_u'(mst_b_id_i);
    assign slv_r_id_o     = idw_pkg::bus_id_u'(mst_r_id_i);
  end

endmodule

// ==== hdl/axi_sram_slave.sv ====
// Single-beat AXI memory slave with byte strobes and registered, held responses
module axi_sram_slave (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             aw_valid_i, w_valid_i, ar_valid_i, b_ready_i, r_ready_i,
  output logic             aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o,
  input  idw_pkg::mem_id_t aw_id_i, ar_id_i,
  input  idw_pkg::addr_t   aw_addr_i, ar_addr_i,
  input  idw_pkg::data_t   w_data_i,
  input  idw_pkg::strb_t   w_strb_i,
  output idw_pkg::mem_id_t b_id_o, r_id_o,
  output idw_pkg::resp_t   b_resp_o, r_resp_o,
  output idw_pkg::data_t   r_data_o
);

  idw_pkg::data_t mem_q [idw_pkg::MemWords];
  logic           wr_fire;
  logic           rd_fire;

  // Address and data go in together, once the previous response has left
  assign aw_ready_o = w_valid_i & !b_valid_o;
  assign w_ready_o  = aw_valid_i & !b_valid_o;
  assign ar_ready_o = !r_valid_o;
  assign wr_fire    = aw_valid_i & w_valid_i & !b_valid_o;
  assign rd_fire    = ar_valid_i & !r_valid_o;
  assign b_resp_o   = idw_pkg::RespOkay;
  assign r_resp_o   = idw_pkg::RespOkay;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_o <= 1'b0;
      r_valid_o <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_o <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_o <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_id_o <= aw_id_i;
      for (int i = 0; i < idw_pkg::StrbWidth; i++) begin
        if (w_strb_i[i]) mem_q[aw_addr_i][8*i +: 8] <= w_data_i[8*i +: 8];
      end
    end
    if (rd_fire) begin
      r_id_o   <= ar_id_i;
      r_data_o <= mem_q[ar_addr_i];
    end
  end

  // Held responses stay put until the requester takes them
  a_b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o));

  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_id_o) && $stable(r_data_o));

endmodule

// ==== hdl/axi_id_subsys.sv ====
// Two requesters sharing one memory through the round-robin mux and the ID width converter
module axi_id_subsys (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Requester 0
  input  logic             req0_aw_valid_i, req0_w_valid_i, req0_ar_valid_i,
  input  logic             req0_b_ready_i, req0_r_ready_i,
  output logic             req0_aw_ready_o, req0_w_ready_o, req0_ar_ready_o,
  output logic             req0_b_valid_o, req0_r_valid_o,
  input  idw_pkg::req_id_t req0_aw_id_i, req0_ar_id_i,
  input  idw_pkg::addr_t   req0_aw_addr_i, req0_ar_addr_i,
  input  idw_pkg::data_t   req0_w_data_i,
  input  idw_pkg::strb_t   req0_w_strb_i,
  output idw_pkg::req_id_t req0_b_id_o, req0_r_id_o,
  output idw_pkg::resp_t   req0_b_resp_o, req0_r_resp_o,
  output idw_pkg::data_t   req0_r_data_o,
  // Requester 1
  input  logic             req1_aw_valid_i, req1_w_valid_i, req1_ar_valid_i,
  input  logic             req1_b_ready_i, req1_r_ready_i,
  output logic             req1_aw_ready_o, req1_w_ready_o, req1_ar_ready_o,
  output logic             req1_b_valid_o, req1_r_valid_o,
  input  idw_pkg::req_id_t req1_aw_id_i, req1_ar_id_i,
  input  idw_pkg::addr_t   req1_aw_addr_i, req1_ar_addr_i,
  input  idw_pkg::data_t   req1_w_data_i,
  input  idw_pkg::strb_t   req1_w_strb_i,
  output idw_pkg::req_id_t req1_b_id_o, req1_r_id_o,
  output idw_pkg::resp_t   req1_b_resp_o, req1_r_resp_o,
  output idw_pkg::data_t   req1_r_data_o
);

  // Shared bus with prefixed IDs
  logic             bus_aw_valid, bus_aw_ready, bus_w_valid, bus_w_ready;
  logic             bus_b_valid, bus_b_ready, bus_ar_valid, bus_ar_ready;
  logic             bus_r_valid, bus_r_ready;
  idw_pkg::bus_id_u bus_aw_id, bus_b_id, bus_ar_id, bus_r_id;
  idw_pkg::addr_t   bus_aw_addr, bus_ar_addr;
  idw_pkg::data_t   bus_w_data, bus_r_data;
  idw_pkg::strb_t   bus_w_strb;
  idw_pkg::resp_t   bus_b_resp, bus_r_resp;

  // Memory side with remapped IDs
  logic             mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
  logic             mem_b_valid, mem_b_ready, mem_ar_valid, mem_ar_ready;
  logic             mem_r_valid, mem_r_ready;
  idw_pkg::mem_id_t mem_aw_id, mem_b_id, mem_ar_id, mem_r_id;
  idw_pkg::addr_t   mem_aw_addr, mem_ar_addr;
  idw_pkg::data_t   mem_w_data, mem_r_data;
  idw_pkg::strb_t   mem_w_strb;
  idw_pkg::resp_t   mem_b_resp, mem_r_resp;

  // Requester ports share their names with the top level
  axi_rr_id_mux i_axi_rr_id_mux (
    .*,
    .bus_aw_valid_o (bus_aw_valid), .bus_aw_id_o (bus_aw_id), .bus_aw_addr_o (bus_aw_addr),
    .bus_aw_ready_i (bus_aw_ready),
    .bus_w_valid_o  (bus_w_valid), .bus_w_data_o (bus_w_data), .bus_w_strb_o (bus_w_strb),
    .bus_w_ready_i  (bus_w_ready),
    .bus_b_valid_i  (bus_b_valid), .bus_b_id_i (bus_b_id), .bus_b_resp_i (bus_b_resp),
    .bus_b_ready_o  (bus_b_ready),
    .bus_ar_valid_o (bus_ar_valid), .bus_ar_id_o (bus_ar_id), .bus_ar_addr_o (bus_ar_addr),
    .bus_ar_ready_i (bus_ar_ready),
    .bus_r_valid_i  (bus_r_valid), .bus_r_id_i (bus_r_id), .bus_r_resp_i (bus_r_resp),
    .bus_r_data_i   (bus_r_data), .bus_r_ready_o (bus_r_ready)
  );

  axi_iw_converter #(
    .IdWidthSlv (idw_pkg::IdWidthBus),
    .IdWidthMst (idw_pkg::IdWidthMem)
  ) i_axi_iw_converter (
    .clk_i,
    .rst_n_i,
    .slv_aw_valid_i (bus_aw_valid), .slv_aw_id_i (bus_aw_id), .slv_aw_addr_i (bus_aw_addr),
    .slv_aw_ready_o (bus_aw_ready),
    .slv_w_valid_i  (bus_w_valid), .slv_w_data_i (bus_w_data), .slv_w_strb_i (bus_w_strb),
    .slv_w_ready_o  (bus_w_ready),
    .slv_b_valid_o  (bus_b_valid), .slv_b_id_o (bus_b_id), .slv_b_resp_o (bus_b_resp),
    .slv_b_ready_i  (bus_b_ready),
    .slv_ar_valid_i (bus_ar_valid), .slv_ar_id_i (bus_ar_id), .slv_ar_addr_i (bus_ar_addr),
    .slv_ar_ready_o (bus_ar_ready),
    .slv_r_valid_o  (bus_r_valid), .slv_r_id_o (bus_r_id), .slv_r_resp_o (bus_r_resp),
    .slv_r_data_o   (bus_r_data), .slv_r_ready_i (bus_r_ready),
    .mst_aw_valid_o (mem_aw_valid), .mst_aw_id_o (mem_aw_id), .mst_aw_addr_o (mem_aw_addr),
    .mst_aw_ready_i (mem_aw_ready),
    .mst_w_valid_o  (mem_w_valid), .mst_w_data_o (mem_w_data), .mst_w_strb_o (mem_w_strb),
    .mst_w_ready_i  (mem_w_ready),
    .mst_b_valid_i  (mem_b_valid), .mst_b_id_i (mem_b_id), .mst_b_resp_i (mem_b_resp),
    .mst_b_ready_o  (mem_b_ready),
    .mst_ar_valid_o (mem_ar_valid), .mst_ar_id_o (mem_ar_id), .mst_ar_addr_o (mem_ar_addr),
    .mst_ar_ready_i (mem_ar_ready),
    .mst_r_valid_i  (mem_r_valid), .mst_r_id_i (mem_r_id), .mst_r_resp_i (mem_r_resp),
    .mst_r_data_i   (mem_r_data), .mst_r_ready_o (mem_r_ready)
  );

  axi_sram_slave i_axi_sram_slave (
    .clk_i,
    .rst_n_i,
    .aw_valid_i (mem_aw_valid), .aw_id_i (mem_aw_id), .aw_addr_i (mem_aw_addr),
    .aw_ready_o (mem_aw_ready),
    .w_valid_i  (mem_w_valid), .w_data_i (mem_w_data), .w_strb_i (mem_w_strb),
    .w_ready_o  (mem_w_ready),
    .b_valid_o  (mem_b_valid), .b_id_o (mem_b_id), .b_resp_o (mem_b_resp),
    .b_ready_i  (mem_b_ready),
    .ar_valid_i (mem_ar_valid), .ar_id_i (mem_ar_id), .ar_addr_i (mem_ar_addr),
    .ar_ready_o (mem_ar_ready),
    .r_valid_o  (mem_r_valid), .r_id_o (mem_r_id), .r_resp_o (mem_r_resp),
    .r_data_o   (mem_r_data), .r_ready_i (mem_r_ready)
  );

endmodule

// ==== test/axi_id_subsys_tb.sv ====
// Testbench for the AXI ID slice with two random requesters, a reference memory and response checks
module axi_id_subsys_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTxn         = 200;
  localparam int MaxOutstanding = 3;
  localparam int TimeoutCycles  = 2 * NumTxn * 2 * 8;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic             aw_valid [2], w_valid [2], ar_valid [2], b_ready [2], r_ready [2];
  logic             aw_ready [2], w_ready [2], ar_ready [2], b_valid [2], r_valid [2];
  idw_pkg::req_id_t aw_id [2], ar_id [2], b_id [2], r_id [2];
  idw_pkg::addr_t   aw_addr [2], ar_addr [2];
  idw_pkg::data_t   w_data [2], r_data [2];
  idw_pkg::strb_t   w_strb [2];
  idw_pkg::resp_t   b_resp [2], r_resp [2];

  // Reference memory and the responses each requester still expects
  idw_pkg::data_t   ref_mem [idw_pkg::MemWords];
  bit               known [idw_pkg::MemWords];
  int               pend_wr [idw_pkg::MemWords];
  idw_pkg::req_id_t exp_b_id [2][$];
  idw_pkg::addr_t   exp_b_addr [2][$];
  idw_pkg::req_id_t exp_r_id [2][$];
  idw_pkg::data_t   exp_r_data [2][$];
  int               outstanding [2];
  int               received [2];
  bit               b_held [2];
  bit               r_held [2];
  idw_pkg::req_id_t held_b_id [2], held_r_id [2];
  idw_pkg::data_t   held_r_data [2];
  int               err_data, err_id, err_resp, err_other;
  int               cycles;

  axi_id_subsys i_axi_id_subsys (
    .clk_i,
    .rst_n_i,
    .req0_aw_valid_i (aw_valid[0]), .req0_aw_id_i (aw_id[0]), .req0_aw_addr_i (aw_addr[0]),
    .req0_aw_ready_o (aw_ready[0]),
    .req0_w_valid_i  (w_valid[0]), .req0_w_data_i (w_data[0]), .req0_w_strb_i (w_strb[0]),
    .req0_w_ready_o  (w_ready[0]),
    .req0_b_valid_o  (b_valid[0]), .req0_b_id_o (b_id[0]), .req0_b_resp_o (b_resp[0]),
    .req0_b_ready_i  (b_ready[0]),
    .req0_ar_valid_i (ar_valid[0]), .req0_ar_id_i (ar_id[0]), .req0_ar_addr_i (ar_addr[0]),
    .req0_ar_ready_o (ar_ready[0]),
    .req0_r_valid_o  (r_valid[0]), .req0_r_id_o (r_id[0]), .req0_r_data_o (r_data[0]),
    .req0_r_resp_o   (r_resp[0]), .req0_r_ready_i (r_ready[0]),
    .req1_aw_valid_i (aw_valid[1]), .req1_aw_id_i (aw_id[1]), .req1_aw_addr_i (aw_addr[1]),
    .req1_aw_ready_o (aw_ready[1]),
    .req1_w_valid_i  (w_valid[1]), .req1_w_data_i (w_data[1]), .req1_w_strb_i (w_strb[1]),
    .req1_w_ready_o  (w_ready[1]),
    .req1_b_valid_o  (b_valid[1]), .req1_b_id_o (b_id[1]), .req1_b_resp_o (b_resp[1]),
    .req1_b_ready_i  (b_ready[1]),
    .req1_ar_valid_i (ar_valid[1]), .req1_ar_id_i (ar_id[1]), .req1_ar_addr_i (ar_addr[1]),
    .req1_ar_ready_o (ar_ready[1]),
    .req1_r_valid_o  (r_valid[1]), .req1_r_id_o (r_id[1]), .req1_r_data_o (r_data[1]),
    .req1_r_resp_o   (r_resp[1]), .req1_r_ready_i (r_ready[1])
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles waiting for a handshake or a response", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_data(input string name, input idw_pkg::data_t got,
                            input idw_pkg::data_t exp);
    if (got !== exp) begin
      err_data++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input idw_pkg::req_id_t got,
                          input idw_pkg::req_id_t exp);
    if (got !== exp) begin
      err_id++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input idw_pkg::resp_t got,
                            input idw_pkg::resp_t exp);
    if (got !== exp) begin
      err_resp++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One request on the bus at a time, up to MaxOutstanding waiting for a response
  task automatic issue_txns(input int k);
    idw_pkg::addr_t   a;
    idw_pkg::data_t   d;
    idw_pkg::strb_t   s;
    idw_pkg::req_id_t id;
    logic             wr;
    logic             done;
    int               n;
    int               i;
    for (n = 0; n < NumTxn; n++) begin
      while (outstanding[k] >= MaxOutstanding) @(negedge clk_i);
      // Even words for requester 0, odd words for requester 1
      a  = idw_pkg::addr_t'(2 * $urandom_range(0, idw_pkg::MemWords / 2 - 1) + k);
      // Reads only go to fully written words with no write in flight
      wr = ($urandom_range(0, 1) == 0) || !known[a] || (pend_wr[a] != 0);
      id = idw_pkg::req_id_t'($urandom_range(0, 3));
      d  = $urandom();
      s  = known[a] ? idw_pkg::strb_t'($urandom_range(1, 15)) : '1;
      if (wr) begin
        aw_valid[k] = 1'b1;
        w_valid[k]  = 1'b1;
        aw_id[k]    = id;
        aw_addr[k]  = a;
        w_data[k]   = d;
        w_strb[k]   = s;
      end else begin
        ar_valid[k] = 1'b1;
        ar_id[k]    = id;
        ar_addr[k]  = a;
      end
      done = 1'b0;
      while (!done) begin
        @(posedge clk_i);
        done = wr ? (aw_ready[k] || w_ready[k]) : ar_ready[k];
      end
      // Address and data of a write transfer on the same edge
      if (wr && (aw_ready[k] !== w_ready[k])) begin
        err_other++;
        $display("Requester %0d write address and data were not accepted together", k);
      end
      outstanding[k]++;
      if (wr) begin
        for (i = 0; i < idw_pkg::StrbWidth; i++) begin
          if (s[i]) ref_mem[a][8*i +: 8] = d[8*i +: 8];
        end
        known[a] = 1'b1;
        pend_wr[a]++;
        exp_b_id[k].push_back(id);
        exp_b_addr[k].push_back(a);
      end else begin
        exp_r_id[k].push_back(id);
        exp_r_data[k].push_back(ref_mem[a]);
      end
      @(negedge clk_i);
      aw_valid[k] = 1'b0;
      w_valid[k]  = 1'b0;
      ar_valid[k] = 1'b0;
      repeat ($urandom_range(0, 2)) @(negedge clk_i);
    end
  endtask

  // A stalled response must still be there with the same payload on the next edge
  task automatic take_responses(input int k);
    idw_pkg::addr_t a;
    if (b_valid[k]) begin
      if (b_held[k]) check_id($sformatf("req%0d_b_id_o", k), b_id[k], held_b_id[k]);
      if (!b_ready[k]) begin
        b_held[k]    = 1'b1;
        held_b_id[k] = b_id[k];
      end else begin
        b_held[k] = 1'b0;
        received[k]++;
        if (exp_b_id[k].size() == 0) begin
          err_other++;
          $display("Requester %0d received a write response it never issued", k);
        end else begin
          check_id($sformatf("req%0d_b_id_o", k), b_id[k], exp_b_id[k].pop_front());
          check_resp($sformatf("req%0d_b_resp_o", k), b_resp[k], idw_pkg::RespOkay);
          a = exp_b_addr[k].pop_front();
          pend_wr[a]--;
          outstanding[k]--;
        end
      end
    end else if (b_held[k]) begin
      err_other++;
      $display("Requester %0d write response vanished before it was accepted", k);
      b_held[k] = 1'b0;
    end
    if (r_valid[k]) begin
      if (r_held[k]) begin
        check_id($sformatf("req%0d_r_id_o", k), r_id[k], held_r_id[k]);
        check_data($sformatf("req%0d_r_data_o", k), r_data[k], held_r_data[k]);
      end
      if (!r_ready[k]) begin
        r_held[k]      = 1'b1;
        held_r_id[k]   = r_id[k];
        held_r_data[k] = r_data[k];
      end else begin
        r_held[k] = 1'b0;
        received[k]++;
        if (exp_r_id[k].size() == 0) begin
          err_other++;
          $display("Requester %0d received a read response it never issued", k);
        end else begin
          check_id($sformatf("req%0d_r_id_o", k), r_id[k], exp_r_id[k].pop_front());
          check_data($sformatf("req%0d_r_data_o", k), r_data[k], exp_r_data[k].pop_front());
          check_resp($sformatf("req%0d_r_resp_o", k), r_resp[k], idw_pkg::RespOkay);
          outstanding[k]--;
        end
      end
    end else if (r_held[k]) begin
      err_other++;
      $display("Requester %0d read response vanished before it was accepted", k);
      r_held[k] = 1'b0;
    end
  endtask

  task automatic watch_responses();
    forever begin
      @(posedge clk_i);
      take_responses(0);
      take_responses(1);
    end
  endtask

  // Roughly one cycle in four stalls each response channel
  task automatic drive_readies();
    forever begin
      @(negedge clk_i);
      for (int k = 0; k < 2; k++) begin
        b_ready[k] = ($urandom_range(0, 3) != 0);
        r_ready[k] = ($urandom_range(0, 3) != 0);
      end
    end
  endtask

  initial begin
    void'($urandom(31681));
    rst_n_i = 1'b0;
    for (int k = 0; k < 2; k++) begin
      aw_valid[k] = 1'b0;
      w_valid[k]  = 1'b0;
      ar_valid[k] = 1'b0;
      b_ready[k]  = 1'b0;
      r_ready[k]  = 1'b0;
      aw_id[k]    = '0;
      ar_id[k]    = '0;
      aw_addr[k]  = '0;
      ar_addr[k]  = '0;
      w_data[k]   = '0;
      w_strb[k]   = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    // Nothing may come back before the first request
    repeat (3) begin
      @(posedge clk_i);
      if (b_valid[0] || b_valid[1] || r_valid[0] || r_valid[1]) begin
        err_other++;
        $display("A response valid is high after reset before any request");
      end
    end
    @(negedge clk_i);
    fork
      drive_readies();
      watch_responses();
    join_none
    fork
      issue_txns(0);
      issue_txns(1);
    join
    while (outstanding[0] != 0 || outstanding[1] != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    for (int k = 0; k < 2; k++) begin
      if (received[k] != NumTxn) begin
        err_other++;
        $display("Requester %0d got %0d responses for %0d requests", k, received[k], NumTxn);
      end
    end
    $display("Error counts: data %0d, id %0d, resp %0d, other %0d",
             err_data, err_id, err_resp, err_other);
    if (err_data + err_id + err_resp + err_other == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== axi_id_subsys.f ====
hdl/idw_pkg.sv
hdl/axi_rr_id_mux.sv
hdl/axi_id_remap_table.sv
hdl/axi_iw_converter.sv
hdl/axi_sram_slave.sv
hdl/axi_id_subsys.sv
test/axi_id_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module axi_id_subsys_tb \
  -f axi_id_subsys.f -o axi_id_subsys_sim || exit 1
out=$(./obj_dir/axi_id_subsys_sim)
echo "$out"
echo "$out" | grep -qx "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
